//--- dspPkg.sv
package dspPkg;

  typedef logic [23:0] instrT;
  typedef logic [13:0] progAddrT;
  typedef logic [13:0] dataAddrT;
  typedef logic [15:0] dataT;
  typedef logic [31:0] accT;

  typedef enum logic {
    SEQ_RUN,
    SEQ_IDLE
  } seqStateT;

  // Opcodes live in bits 23..20 of the instruction word.
  localparam logic [3:0] OP_NOP   = 4'd0;
  localparam logic [3:0] OP_LDI   = 4'd1;
  localparam logic [3:0] OP_LDDAG = 4'd2;
  localparam logic [3:0] OP_ALU   = 4'd3;
  localparam logic [3:0] OP_MAC   = 4'd4;
  localparam logic [3:0] OP_LD    = 4'd5;
  localparam logic [3:0] OP_ST    = 4'd6;
  localparam logic [3:0] OP_JUMP  = 4'd7;
  localparam logic [3:0] OP_JZ    = 4'd8;
  localparam logic [3:0] OP_IDLE  = 4'd15;

  localparam int OP_HI  = 23;
  localparam int OP_LO  = 20;
  localparam int SEL_HI = 19;
  localparam int SEL_LO = 18;
  localparam int IMM_HI = 15;
  localparam int IMM_LO = 0;
  localparam int TGT_HI = 13;
  localparam int TGT_LO = 0;

  localparam logic [1:0] ALU_ADD   = 2'd0;
  localparam logic [1:0] ALU_SUB   = 2'd1;
  localparam logic [1:0] ALU_AND   = 2'd2;
  localparam logic [1:0] ALU_PASSX = 2'd3;

  localparam logic [1:0] MAC_ACC = 2'd0;
  localparam logic [1:0] MAC_MUL = 2'd1;
  localparam logic [1:0] MAC_CLR = 2'd2;

  localparam logic [1:0] DAG_I = 2'd0;
  localparam logic [1:0] DAG_M = 2'd1;
  localparam logic [1:0] DAG_L = 2'd2;
  localparam logic [1:0] DAG_B = 2'd3;

  localparam logic [1:0] SRC_AR  = 2'd0;
  localparam logic [1:0] SRC_MR0 = 2'd1;
  localparam logic [1:0] SRC_MR1 = 2'd2;

  localparam logic [1:0] REG_AX = 2'd0;
  localparam logic [1:0] REG_AY = 2'd1;

endpackage

//--- dspDecoder.sv
`timescale 1ns/1ns

module dspDecoder import dspPkg::*; (
  input  instrT      pmd,
  input  logic       az,
  input  logic       idle,
  output logic       regLoad,
  output logic       aluDo,
  output logic       macDo,
  output logic       ldFromMem,
  output logic       dagLoad,
  output logic       dagStep,
  output logic       dwrite,
  output logic       jumpTaken,
  output logic       goIdle,
  output logic [1:0] regSel,
  output logic [1:0] aluOp,
  output logic [1:0] macOp,
  output logic [1:0] dagSel,
  output logic [1:0] stSel,
  output progAddrT   jumpTarget
);

  logic [3:0] opcode;
  logic [1:0] sel;

  assign opcode = pmd[OP_HI:OP_LO];
  assign sel    = pmd[SEL_HI:SEL_LO];

  // The select field means something different per opcode.
  // Only the strobes decide whether it matters.
  assign regSel     = sel;
  assign aluOp      = sel;
  assign macOp      = sel;
  assign dagSel     = sel;
  assign stSel      = sel;
  assign jumpTarget = pmd[TGT_HI:TGT_LO];

  always_comb begin
    regLoad   = 1'b0;
    aluDo     = 1'b0;
    macDo     = 1'b0;
    ldFromMem = 1'b0;
    dagLoad   = 1'b0;
    dagStep   = 1'b0;
    dwrite    = 1'b0;
    jumpTaken = 1'b0;
    goIdle    = 1'b0;
    if (!idle) begin // Nothing may fire once the core has stopped.
      case (opcode)
        OP_NOP: ;
        OP_LDI: regLoad = 1'b1;
        OP_LDDAG: dagLoad = 1'b1;
        OP_ALU: aluDo = 1'b1;
        OP_MAC: macDo = 1'b1;
        OP_LD: begin
          regLoad   = 1'b1;
          ldFromMem = 1'b1;
          dagStep   = 1'b1; // Post-modify I after the read.
        end
        OP_ST: begin
          dwrite  = 1'b1;
          dagStep = 1'b1;
        end
        OP_JUMP: jumpTaken = 1'b1;
        OP_JZ: jumpTaken = az; // AZ is the flag left by the last ALU instruction.
        OP_IDLE: goIdle = 1'b1;
        default: ; // Unused opcodes behave as NOP.
      endcase
    end
  end

endmodule

//--- dspSequencer.sv
`timescale 1ns/1ns

module dspSequencer import dspPkg::*; (
  input  logic     DSPCLK,
  input  logic     rst,
  input  logic     jumpTaken,
  input  logic     goIdle,
  input  progAddrT jumpTarget,
  output progAddrT pma,
  output logic     idle
);

  seqStateT state;
  seqStateT stateNext;
  progAddrT pmaNext;

  always_comb begin
    stateNext = state;
    pmaNext   = pma;
    case (state)
      SEQ_RUN: begin
        if (goIdle) begin
          stateNext = SEQ_IDLE; // pma stays on the IDLE word.
        end else if (jumpTaken) begin
          pmaNext = jumpTarget;
        end else begin
          pmaNext = pma + progAddrT'(1);
        end
      end
      SEQ_IDLE: begin
        // Only reset leaves this state.
        stateNext = SEQ_IDLE;
      end
      default: stateNext = SEQ_RUN;
    endcase
  end

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      state <= SEQ_RUN;
      pma   <= '0;
    end else begin
      state <= stateNext;
      pma   <= pmaNext;
    end
  end

  assign idle = (state == SEQ_IDLE);

endmodule

//--- dspExecUnit.sv
`timescale 1ns/1ns

module dspExecUnit import dspPkg::*; (
  input  logic       DSPCLK,
  input  logic       rst,
  input  logic       regLoad,
  input  logic       aluDo,
  input  logic       macDo,
  input  logic       ldFromMem,
  input  logic [1:0] regSel,
  input  logic [1:0] aluOp,
  input  logic [1:0] macOp,
  input  logic [1:0] stSel,
  input  dataT       imm,
  input  dataT       dmdIn,
  output logic       az,
  output dataT       dmdOut
);

  dataT ax;
  dataT ay;
  dataT ar;
  accT  mr;
  dataT loadValue;
  dataT aluResult;
  accT  product;
  accT  macResult;

  assign loadValue = ldFromMem ? dmdIn : imm;

  always_comb begin
    case (aluOp)
      ALU_ADD: aluResult = ax + ay;
      ALU_SUB: aluResult = ax - ay;
      ALU_AND: aluResult = ax & ay;
      default: aluResult = ax; // PASSX.
    endcase
  end

  // Full 32-bit signed product of the two 16-bit operands.
  assign product = signed'(ax) * signed'(ay);

  always_comb begin
    case (macOp)
      MAC_ACC: macResult = mr + product;
      MAC_MUL: macResult = product;
      MAC_CLR: macResult = '0;
      default: macResult = mr;
    endcase
  end

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      ax <= '0;
      ay <= '0;
      ar <= '0;
      az <= 1'b0;
      mr <= '0;
    end else begin
      if (regLoad && regSel == REG_AX) ax <= loadValue;
      if (regLoad && regSel == REG_AY) ay <= loadValue;
      if (aluDo) begin
        ar <= aluResult;
        az <= (aluResult == '0);
      end
      if (macDo) mr <= macResult;
    end
  end

  always_comb begin
    case (stSel)
      SRC_MR0: dmdOut = mr[15:0];
      SRC_MR1: dmdOut = mr[31:16];
      default: dmdOut = ar;
    endcase
  end

endmodule

//--- dspDag.sv
`timescale 1ns/1ns

module dspDag import dspPkg::*; (
  input  logic       DSPCLK,
  input  logic       rst,
  input  logic       dagLoad,
  input  logic       dagStep,
  input  logic [1:0] dagSel,
  input  dataAddrT   imm,
  output dataAddrT   dma
);

  dataAddrT iReg;
  dataAddrT mReg;
  dataAddrT lReg;
  dataAddrT bReg;
  dataAddrT iNext;

  // Two spare bits so that the sum can go below zero or past the top.
  logic signed [15:0] stepped;
  logic signed [15:0] upper;
  logic signed [15:0] lower;
  logic signed [15:0] length;

  assign stepped = signed'({2'b00, iReg}) + signed'({{2{mReg[13]}}, mReg});
  assign lower   = signed'({2'b00, bReg});
  assign length  = signed'({2'b00, lReg});
  assign upper   = lower + length;

  always_comb begin
    iNext = stepped[13:0];
    if (lReg != '0) begin // L of zero means linear addressing.
      if (stepped >= upper) begin
        iNext = dataAddrT'(stepped - length);
      end else if (stepped < lower) begin
        iNext = dataAddrT'(stepped + length);
      end
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      iReg <= '0;
      mReg <= '0;
      lReg <= '0;
      bReg <= '0;
    end else if (dagLoad) begin
      case (dagSel)
        DAG_I: iReg <= imm;
        DAG_M: mReg <= imm;
        DAG_L: lReg <= imm;
        DAG_B: bReg <= imm;
        default: iReg <= imm;
      endcase
    end else if (dagStep) begin
      iReg <= iNext;
    end
  end

  assign dma = iReg; // The access uses I before the post-modify.

endmodule

//--- dspCore.sv
`timescale 1ns/1ns

module dspCore import dspPkg::*; (
  input  logic     DSPCLK,
  input  logic     rst,
  output progAddrT pma,
  input  instrT    pmd,
  output dataAddrT dma,
  input  dataT     dmdIn,
  output dataT     dmdOut,
  output logic     dwrite,
  output logic     idle
);

  logic       hold;
  logic       az;
  logic       regLoad;
  logic       aluDo;
  logic       macDo;
  logic       ldFromMem;
  logic       dagLoad;
  logic       dagStep;
  logic       jumpTaken;
  logic       goIdle;
  logic [1:0] regSel;
  logic [1:0] aluOp;
  logic [1:0] macOp;
  logic [1:0] dagSel;
  logic [1:0] stSel;
  progAddrT   jumpTarget;

  assign hold = idle | rst; // No strobe and no store while reset is held.

  dspDecoder decoder (
    .pmd(pmd), .az(az), .idle(hold),
    .regLoad(regLoad), .aluDo(aluDo), .macDo(macDo), .ldFromMem(ldFromMem),
    .dagLoad(dagLoad), .dagStep(dagStep), .dwrite(dwrite),
    .jumpTaken(jumpTaken), .goIdle(goIdle),
    .regSel(regSel), .aluOp(aluOp), .macOp(macOp), .dagSel(dagSel), .stSel(stSel),
    .jumpTarget(jumpTarget)
  );

  dspSequencer sequencer (
    .DSPCLK(DSPCLK), .rst(rst), .jumpTaken(jumpTaken), .goIdle(goIdle),
    .jumpTarget(jumpTarget), .pma(pma), .idle(idle)
  );

  dspExecUnit execUnit (
    .DSPCLK(DSPCLK), .rst(rst),
    .regLoad(regLoad), .aluDo(aluDo), .macDo(macDo), .ldFromMem(ldFromMem),
    .regSel(regSel), .aluOp(aluOp), .macOp(macOp), .stSel(stSel),
    .imm(pmd[IMM_HI:IMM_LO]), .dmdIn(dmdIn), .az(az), .dmdOut(dmdOut)
  );

  dspDag dag (
    .DSPCLK(DSPCLK), .rst(rst), .dagLoad(dagLoad), .dagStep(dagStep), .dagSel(dagSel),
    .imm(pmd[IMM_LO +: $bits(dataAddrT)]), .dma(dma)
  );

endmodule

//--- tbDspCore_assert.sv
`timescale 1ns/1ns

module tbDspCore_assert import dspPkg::*; (
  input logic     DSPCLK,
  input logic     rst,
  input progAddrT pma,
  input logic     dwrite,
  input logic     idle
);

  // A stopped core never writes data memory.
  noStoreWhileIdle: assert property (@(posedge DSPCLK) disable iff (rst) idle |-> !dwrite)
    else $error("dwrite is high while the core is idle");

  idleIsSticky: assert property (@(posedge DSPCLK) disable iff (rst) idle |=> idle)
    else $error("idle fell without a reset");

  pmaFrozen: assert property (@(posedge DSPCLK) disable iff (rst) idle |=> $stable(pma))
    else $error("pma moved while the core is idle"); // Sequencer must hold the IDLE word.

endmodule

bind dspCore tbDspCore_assert checks (.*);

//--- tbDspCore.sv
`timescale 1ns/1ns

module tbDspCore import dspPkg::*; ();

  logic DSPCLK = 1'b0;
  logic rst = 1'b1;
  progAddrT pma;
  instrT pmd;
  dataAddrT dma;
  dataT dmdIn, dmdOut;
  logic dwrite, idle;

  instrT progMem [0:16383];
  dataT dataMem [0:16383];
  dataT refMem [0:16383]; // Data image as the reference interpreter leaves it.
  logic [31:0] lfsr = 32'h49d4_7a45;
  int progLen = 0;
  int testErrors = 0;
  int passCount = 0;
  int failCount = 0;

  always #50 DSPCLK = ~DSPCLK;

  assign pmd = progMem[pma];
  assign dmdIn = dataMem[dma];

  always @(posedge DSPCLK) begin
    if (dwrite) dataMem[dma] = dmdOut;
  end

  dspCore dut (.*);

  function automatic instrT encode(logic [3:0] op, logic [1:0] sel, logic [15:0] imm);
    return {op, sel, 2'b00, imm};
  endfunction

  // Galois LFSR that is stepped once for every bit handed out.
  function automatic logic [31:0] randomBits(int count);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < count; k++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  function automatic instrT randomInstr();
    logic [2:0] kind;
    logic [1:0] sel;
    logic [15:0] value;
    kind = 3'(randomBits(3));
    sel = 2'(randomBits(2));
    value = 16'(randomBits(16));
    case (kind)
      3'd0: return encode(OP_LDI, {1'b0, sel[0]}, value);
      3'd1: begin
        // Only I and M change here, so every access stays inside the buffer.
        if (sel[0]) return encode(OP_LDDAG, DAG_M, {{13{value[2]}}, value[2:0]});
        return encode(OP_LDDAG, DAG_I, {12'h010, value[3:0]});
      end
      3'd2: return encode(OP_ALU, sel, value);
      3'd3: return encode(OP_MAC, (sel == 2'd3) ? MAC_ACC : sel, value);
      3'd4: return encode(OP_LD, {1'b0, sel[0]}, value);
      default: return encode(OP_ST, (sel == 2'd3) ? SRC_AR : sel, value);
    endcase
  endfunction

  // Post-modify with circular wrap. M is taken as 14-bit two's complement.
  function automatic dataAddrT modelStep(dataAddrT i, dataAddrT m, dataAddrT l, dataAddrT b);
    int s;
    s = int'(i) + (m[13] ? int'(m) - 16384 : int'(m));
    if (l != '0) begin
      if (s >= int'(b) + int'(l)) s = s - int'(l);
      else if (s < int'(b)) s = s + int'(l);
    end
    return dataAddrT'(s);
  endfunction

  function automatic void runModel();
    progAddrT pc = '0;
    instrT w;
    logic [1:0] sel;
    dataT ax = '0, ay = '0, ar = '0;
    dataAddrT i = '0, m = '0, l = '0, b = '0;
    logic [31:0] mr = '0;
    int product;
    logic az = 1'b0;
    for (int n = 0; n < 2000; n++) begin
      w = progMem[pc];
      sel = w[19:18];
      pc = pc + progAddrT'(1);
      product = int'($signed(ax)) * int'($signed(ay));
      case (w[23:20])
        OP_LDI: begin
          if (sel == REG_AY) ay = w[15:0];
          else ax = w[15:0];
        end
        OP_LDDAG: begin
          case (sel)
            DAG_I: i = w[13:0];
            DAG_M: m = w[13:0];
            DAG_L: l = w[13:0];
            default: b = w[13:0];
          endcase
        end
        OP_ALU: begin
          case (sel)
            ALU_ADD: ar = ax + ay;
            ALU_SUB: ar = ax - ay;
            ALU_AND: ar = ax & ay;
            default: ar = ax;
          endcase
          az = (ar == '0);
        end
        OP_MAC: begin
          if (sel == MAC_ACC) mr = mr + product;
          else if (sel == MAC_MUL) mr = product;
          else if (sel == MAC_CLR) mr = '0;
        end
        OP_LD: begin
          if (sel == REG_AY) ay = refMem[i];
          else ax = refMem[i];
          i = modelStep(i, m, l, b);
        end
        OP_ST: begin
          case (sel)
            SRC_MR0: refMem[i] = mr[15:0];
            SRC_MR1: refMem[i] = mr[31:16];
            default: refMem[i] = ar;
          endcase
          i = modelStep(i, m, l, b);
        end
        OP_JUMP: pc = w[13:0];
        OP_JZ: if (az) pc = w[13:0];
        OP_IDLE: return;
        default: ;
      endcase
    end
  endfunction

  task automatic loadImages();
    for (int a = 0; a < 16384; a++) begin
      progMem[a] = {OP_IDLE, 6'b0, 14'(a)}; // Stray fetches stop the core.
      dataMem[a] = dataT'(a * 40503) ^ 16'h5a5a;
    end
    progLen = 0;
  endtask

  task automatic put(instrT word);
    progMem[progLen] = word;
    progLen++;
  endtask

  task automatic checkWindow(string name, int lo, int hi);
    for (int a = lo; a <= hi; a++) begin
      if (dataMem[a] !== refMem[a]) begin
        $display("ERROR %s addr %h expected %h actual %h", name, 14'(a), refMem[a], dataMem[a]);
        testErrors++;
      end
    end
  endtask

  task automatic runTest(string name, int lo, int hi);
    progAddrT held;
    int n;
    testErrors = 0;
    refMem = dataMem;
    @(negedge DSPCLK);
    rst = 1'b1;
    repeat (3) @(negedge DSPCLK);
    if (pma !== '0 || idle !== 1'b0 || dwrite !== 1'b0) begin
      $display("ERROR %s reset expected pma 0000 idle 0 dwrite 0 actual pma %h idle %b dwrite %b",
               name, pma, idle, dwrite);
      testErrors++;
    end
    rst = 1'b0;
    for (n = 0; n < 2000 && idle !== 1'b1; n++) @(negedge DSPCLK);
    if (idle !== 1'b1) begin
      $display("%s: the core did not reach idle within 2000 cycles", name);
      testErrors++;
    end else begin
      runModel();
      checkWindow(name, lo, hi);
      held = pma;
      for (n = 0; n < 10; n++) begin
        @(negedge DSPCLK);
        if (pma !== held || dwrite !== 1'b0) begin
          $display("ERROR %s idle hold expected pma %h dwrite 0 actual pma %h dwrite %b",
                   name, held, pma, dwrite);
          testErrors++;
        end
      end
    end
    if (testErrors == 0) begin
      passCount++;
      $display("PASS %s", name);
    end else begin
      failCount++;
      $display("FAIL %s with %0d errors", name, testErrors);
    end
  endtask

  initial begin
    int top;
    loadImages();
    put(encode(OP_LDDAG, DAG_I, 16'h0040));
    put(encode(OP_LDDAG, DAG_M, 16'h0001));
    put(encode(OP_LDI, REG_AX, 16'h1234));
    put(encode(OP_LDI, REG_AY, 16'h0ff1));
    for (int k = 0; k < 4; k++) begin
      put(encode(OP_ALU, 2'(k), 16'h0));
      put(encode(OP_ST, SRC_AR, 16'h0));
    end
    put(encode(OP_LDI, REG_AY, 16'h8001));
    put(encode(OP_ALU, ALU_SUB, 16'h0));
    put(encode(OP_ST, SRC_AR, 16'h0));
    put(encode(OP_IDLE, 2'd0, 16'h0));
    runTest("alu", 'h3c, 'h4f);

    loadImages();
    put(encode(OP_ST, SRC_MR1, 16'h0)); // MR and I still hold their reset values.
    put(encode(OP_LDDAG, DAG_I, 16'h0060));
    put(encode(OP_LDDAG, DAG_M, 16'h0001));
    put(encode(OP_LDI, REG_AX, 16'hfffd));
    put(encode(OP_LDI, REG_AY, 16'h1234));
    put(encode(OP_MAC, MAC_MUL, 16'h0));
    put(encode(OP_LDI, REG_AX, 16'h8000));
    put(encode(OP_LDI, REG_AY, 16'h7fff));
    put(encode(OP_MAC, MAC_ACC, 16'h0));
    put(encode(OP_LDI, REG_AY, 16'h8000));
    put(encode(OP_MAC, MAC_ACC, 16'h0));
    put(encode(OP_MAC, MAC_ACC, 16'h0));
    put(encode(OP_ST, SRC_MR0, 16'h0));
    put(encode(OP_ST, SRC_MR1, 16'h0));
    put(encode(OP_MAC, MAC_CLR, 16'h0));
    put(encode(OP_ST, SRC_MR0, 16'h0));
    put(encode(OP_ST, SRC_MR1, 16'h0));
    put(encode(OP_IDLE, 2'd0, 16'h0));
    runTest("mac", 'h00, 'h6f);

    loadImages();
    put(encode(OP_LDDAG, DAG_B, 16'h0080));
    put(encode(OP_LDDAG, DAG_L, 16'h0005));
    put(encode(OP_LDDAG, DAG_I, 16'h0082));
    put(encode(OP_LDDAG, DAG_M, 16'h0002));
    for (int k = 0; k < 14; k++) begin
      if (k == 7) put(encode(OP_LDDAG, DAG_M, 16'h3ffd)); // M of -3 for the second half.
      put(encode(OP_LDI, REG_AX, 16'h1000 + 16'(k)));
      put(encode(OP_ALU, ALU_PASSX, 16'h0));
      put(encode(OP_ST, SRC_AR, 16'h0));
    end
    put(encode(OP_IDLE, 2'd0, 16'h0));
    runTest("circular", 'h78, 'h8f);

    loadImages();
    put(encode(OP_LDDAG, DAG_I, 16'h00a0));
    put(encode(OP_LDDAG, DAG_M, 16'h0000));
    put(encode(OP_LDI, REG_AX, 16'h0005));
    put(encode(OP_LDI, REG_AY, 16'h0001));
    top = progLen;
    // AX counts down through the word at 0x00a0 while MR sums the counts.
    put(encode(OP_MAC, MAC_ACC, 16'h0));
    put(encode(OP_ALU, ALU_SUB, 16'h0));
    put(encode(OP_ST, SRC_AR, 16'h0));
    put(encode(OP_LD, REG_AX, 16'h0));
    put(encode(OP_JZ, 2'd0, 16'(progLen + 2)));
    put(encode(OP_JUMP, 2'd0, 16'(top)));
    put(encode(OP_LDDAG, DAG_I, 16'h00b0));
    put(encode(OP_LDDAG, DAG_M, 16'h0001));
    put(encode(OP_JUMP, 2'd0, 16'(progLen + 2)));
    put(encode(OP_ST, SRC_AR, 16'h0)); // Skipped by the jump.
    put(encode(OP_ST, SRC_MR0, 16'h0));
    put(encode(OP_ST, SRC_MR1, 16'h0));
    put(encode(OP_IDLE, 2'd0, 16'h0));
    runTest("control", 'h9c, 'hb7);

    for (int p = 0; p < 4; p++) begin
      loadImages();
      put(encode(OP_LDDAG, DAG_B, 16'h0100));
      put(encode(OP_LDDAG, DAG_L, 16'h0010));
      put(encode(OP_LDDAG, DAG_I, 16'h0100));
      put(encode(OP_LDDAG, DAG_M, 16'h0001));
      while (progLen < 23) put(randomInstr());
      put(encode(OP_IDLE, 2'd0, 16'h0));
      runTest($sformatf("random%0d", p), 'hf0, 'h11f);
    end

    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- flist.f
dspPkg.sv
dspDecoder.sv
dspSequencer.sv
dspExecUnit.sv
dspDag.sv
dspCore.sv
tbDspCore_assert.sv
tbDspCore.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tbDspCore
FILELIST  ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
